//--- common/quadric_pkg.sv
// shared types and constants for the ray / unit quadric intersection pipeline
package quadric_pkg;

    // coordinates are signed q8.8
    localparam int frac_w = 8;

    typedef logic signed [15:0] coord_t;

    // products land in q16.16, three of them are summed, then doubled and biased
    localparam int coeff_w = 36;

    typedef logic signed [coeff_w-1:0] coeff_val_t;

    // 1.0 at product scale (q16.16), bias for 2c
    localparam coeff_val_t fix_one = coeff_val_t'(1) <<< (2 * frac_w);

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;                       // 48 bits

    // shape codes follow the scene encoding
    typedef enum logic [1:0] {
        shape_off,                  // slot unused, forced to a harmless quadratic
        shape_sphere,
        shape_cylinder,             // infinite along z
        shape_cone                  // apex at origin, axis along z
    } shape_t;

    typedef struct packed {
        vec3_t  src;                // ray origin
        vec3_t  dir;                // ray direction, not normalised
        shape_t shape;
    } ray_t;                        // 98 bits

    typedef struct packed {
        coeff_val_t a2;             // 2a
        coeff_val_t b;
        coeff_val_t c2;             // 2c
    } coeff_t;                      // 108 bits

    typedef struct packed {
        coeff_t coeff;
        logic   real_sol;           // discriminant >= 0
        logic   real_pos_sol;       // some root t > 0
    } hit_t;                        // 110 bits

endpackage

//--- quadric/signed_dot3.sv
`timescale 1ns/1ns

// 2 * (+-a.x*b.x +- a.y*b.y +- a.z*b.z), two register stages
module signed_dot3 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  quadric_pkg::vec3_t      a,
    input  quadric_pkg::vec3_t      b,
    input  logic [2:0]              neg,        // bit 0 = x term, bit 2 = z term
    output logic                    out_valid,
    output quadric_pkg::coeff_val_t dot2
);
    import quadric_pkg::*;

    localparam int prod_w = 2 * $bits(coord_t);    // full q16.16 product

    coord_t                   av [3];
    coord_t                   bv [3];
    logic signed [prod_w-1:0] prod_d [3];
    logic signed [prod_w-1:0] prod_q [3];
    logic                     prod_valid;

    assign av = '{a.x, a.y, a.z};
    assign bv = '{b.x, b.y, b.z};

    // signed multiply per lane, optional negate
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            prod_d[i] = av[i] * bv[i];
            if (neg[i]) prod_d[i] = -prod_d[i];  // |prod| <= 2^30, no overflow
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            out_valid  <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= prod_d;
        // sign extend before adding so the sum stays exact
        dot2   <= (coeff_val_t'(prod_q[0]) + coeff_val_t'(prod_q[1])
                  + coeff_val_t'(prod_q[2])) <<< 1;
    end

endmodule

//--- quadric/quadric_coeff.sv
`timescale 1ns/1ns

// builds 2a, b and 2c of |src + t*dir|_q = 1 for the selected unit quadric
// latency 4: select reg, 2 in the dot products, bias reg
module quadric_coeff (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ray_valid,
    input  quadric_pkg::ray_t   ray,
    output logic                coeff_valid,
    output quadric_pkg::coeff_t coeff
);
    import quadric_pkg::*;

    localparam coord_t     unit_coord = coord_t'(1 << frac_w);     // 1.0 in q8.8
    localparam vec3_t      unit_vec   = '{x: unit_coord, y: coord_t'(0), z: coord_t'(0)};
    localparam coeff_val_t bias_2c    = fix_one <<< 1;             // 2 * 1.0

    // operand selection, combinational
    vec3_t      dd_op_d;            // dir.dir operand
    vec3_t      ds_src_d;           // src side of dir.src
    vec3_t      ss_op_d;            // src.src operand
    logic [2:0] neg_d;
    logic       bias_d;

    // entry registers
    logic       sel_valid;
    vec3_t      dd_op_q;
    vec3_t      ds_dir_q;
    vec3_t      ds_src_q;
    vec3_t      ss_op_q;
    logic [2:0] neg_q;
    logic       bias_q;

    // bias flag rides next to the dot product pipe
    logic       bias_p1;
    logic       bias_p2;

    logic       dot_valid;
    coeff_val_t dd_dot2;
    coeff_val_t ds_dot2;
    coeff_val_t ss_dot2;

    always_comb begin
        dd_op_d  = ray.dir;
        ds_src_d = ray.src;
        ss_op_d  = ray.src;
        neg_d    = 3'b000;
        bias_d   = 1'b1;                // sphere and cylinder: x^2 + y^2 (+ z^2) - 1
        case (ray.shape)
            shape_off: begin
                dd_op_d  = unit_vec;    // 2a = 2
                ds_src_d = '0;          // b = 0
                ss_op_d  = unit_vec;    // 2c = 2 - 2 = 0
            end
            shape_cylinder: begin
                dd_op_d.z  = '0;
                ds_src_d.z = '0;        // dir.z drops out through src.z = 0
                ss_op_d.z  = '0;
            end
            shape_cone: begin
                neg_d  = 3'b100;        // x^2 + y^2 - z^2
                bias_d = 1'b0;          // no -1 term for a cone
            end
            default: begin
                // sphere keeps the full vectors
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_valid   <= 1'b0;
            coeff_valid <= 1'b0;
        end else begin
            sel_valid   <= ray_valid;
            coeff_valid <= dot_valid;
        end
    end

    always_ff @(posedge clk) begin
        dd_op_q  <= dd_op_d;
        ds_dir_q <= ray.dir;
        ds_src_q <= ds_src_d;
        ss_op_q  <= ss_op_d;
        neg_q    <= neg_d;
        bias_q   <= bias_d;
        bias_p1  <= bias_q;
        bias_p2  <= bias_p1;
        coeff.a2 <= dd_dot2;            // delayed to line up with 2c
        coeff.b  <= ds_dot2;
        coeff.c2 <= bias_p2 ? ss_dot2 - bias_2c : ss_dot2;
    end

    signed_dot3 dot_dir_dir (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sel_valid),
        .a         (dd_op_q),
        .b         (dd_op_q),
        .neg       (neg_q),
        .out_valid (dot_valid),         // all three instances run in lockstep
        .dot2      (dd_dot2)
    );

    signed_dot3 dot_dir_src (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sel_valid),
        .a         (ds_dir_q),
        .b         (ds_src_q),
        .neg       (neg_q),
        .out_valid (),
        .dot2      (ds_dot2)
    );

    signed_dot3 dot_src_src (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sel_valid),
        .a         (ss_op_q),
        .b         (ss_op_q),
        .neg       (neg_q),
        .out_valid (),
        .dot2      (ss_dot2)
    );

    a_shape_known: assert property (@(posedge clk) disable iff (!rst_n)
        ray_valid |-> !$isunknown(ray.shape))
        else $error("ray shape is unknown while ray_valid is high");

endmodule

//--- logic/root_classify.sv
`timescale 1ns/1ns

// classifies the roots of a*t^2 + b*t + c from 2a, b, 2c
// latency 2: products, then discriminant and flags
module root_classify (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                coeff_valid,
    input  quadric_pkg::coeff_t coeff,
    output logic                hit_valid,
    output quadric_pkg::hit_t   hit
);
    import quadric_pkg::*;

    localparam int prod_w = 2 * coeff_w;    // exact product of two coefficients
    localparam int disc_w = prod_w + 1;     // room for b^2 - 4ac

    logic                     s1_valid;
    coeff_t                   s1_coeff;
    logic signed [prod_w-1:0] s1_b_sq;
    logic signed [prod_w-1:0] s1_ac4;      // (2a)(2c) = 4ac
    logic                     s1_a2_zero;
    logic                     s1_c2_opp;   // c2 nonzero, sign opposite to a2
    logic                     s1_b_opp;    // b nonzero, sign opposite to a2
    logic signed [disc_w-1:0] disc;
    logic                     disc_ge0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            s1_valid  <= coeff_valid;
            hit_valid <= s1_valid;
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        s1_coeff   <= coeff;
        s1_b_sq    <= coeff.b * coeff.b;
        s1_ac4     <= coeff.a2 * coeff.c2;
        s1_a2_zero <= (coeff.a2 == '0);
        s1_c2_opp  <= (coeff.c2 != '0) && (coeff.c2[coeff_w-1] != coeff.a2[coeff_w-1]);
        s1_b_opp   <= (coeff.b != '0) && (coeff.b[coeff_w-1] != coeff.a2[coeff_w-1]);
    end

    assign disc     = s1_b_sq - s1_ac4;     // operands sign extended to disc_w
    assign disc_ge0 = !disc[disc_w-1];

    // stage 2
    // c/a < 0 gives roots of opposite sign, one positive
    // otherwise the roots share a sign and -b/a > 0 makes it positive
    // (c = 0 leaves roots 0 and -b/a, same test)
    always_ff @(posedge clk) begin
        hit.coeff        <= s1_coeff;
        hit.real_sol     <= disc_ge0;
        hit.real_pos_sol <= !s1_a2_zero && disc_ge0 && (s1_c2_opp || s1_b_opp);  // a = 0 is a miss
    end

    a_pos_implies_real: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> (!hit.real_pos_sol || hit.real_sol))
        else $error("real_pos_sol set without real_sol");

endmodule

//--- logic/ray_quadric_top.sv
`timescale 1ns/1ns

// ray vs unit quadric, one ray per cycle, hit_valid 6 cycles after ray_valid
module ray_quadric_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ray_valid,
    input  quadric_pkg::ray_t ray,
    output logic              hit_valid,
    output quadric_pkg::hit_t hit
);
    import quadric_pkg::*;

    // producer -> consumer
    logic   coeff_valid;
    coeff_t coeff;          // 2a, b, 2c

    // 4 cycles
    quadric_coeff u_coeff (
        .clk         (clk),
        .rst_n       (rst_n),
        .ray_valid   (ray_valid),
        .ray         (ray),
        .coeff_valid (coeff_valid),
        .coeff       (coeff)
    );

    // 2 cycles
    root_classify u_classify (
        .clk         (clk),
        .rst_n       (rst_n),
        .coeff_valid (coeff_valid),
        .coeff       (coeff),
        .hit_valid   (hit_valid),
        .hit         (hit)
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

// free running clock and power-on reset for the testbench
module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 5;    // 10 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- dv/tb_ray_quadric.sv
`timescale 1ns/1ns

// ray vs unit quadric pipeline, directed and lfsr driven rays
module tb_ray_quadric;
    import quadric_pkg::*;

    localparam longint q16_one     = 65536;         // 1.0 * 1.0 in q8.8 squared
    localparam int     random_rays = 410;
    // 10 reset + 10 directed + 410 rays with at most one gap each + drain, rounded up
    localparam int     cycle_limit = 1000;

    logic        clk;
    logic        rst_n;
    logic        ray_valid;
    ray_t        ray;
    logic        hit_valid;
    hit_t        hit;

    hit_t        exp_q[$];      // model results, oldest first
    hit_t        exp_head;      // front of exp_q, only changes on the falling edge
    logic        exp_avail;
    logic        hit_sampled;   // hit_valid as seen by the last rising edge
    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    int          rays_sent;
    int          hits_checked;
    int          cycle_count = 0;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ray_quadric_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ray_valid (ray_valid),
        .ray       (ray),
        .hit_valid (hit_valid),
        .hit       (hit)
    );

    task automatic report_value(input string name, input longint exp, input longint act);
        value_errors++;
        $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    endtask

    task automatic report_other(input string msg);
        other_errors++;
        $display("at %0t: %s", $time, msg);
    endtask

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);     // one step per bit
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic random_coord(output coord_t v);
        logic [15:0] bits;
        take_bits(1, bits);
        if (bits[0]) begin
            take_bits(16, bits);        // full q8.8 range, exercises the widths
            v = coord_t'(bits);
        end else begin
            take_bits(12, bits);        // +-8.0, near the unit shape
            v = coord_t'({{4{bits[11]}}, bits[11:0]});
        end
    endtask

    task automatic random_ray(output ray_t r);
        logic [15:0] bits;
        coord_t      c [6];
        take_bits(2, bits);
        r.shape = shape_t'(bits[1:0]);  // off shows up too
        for (int i = 0; i < 6; i++) begin
            random_coord(c[i]);
        end
        r.src = '{x: c[0], y: c[1], z: c[2]};
        r.dir = '{x: c[3], y: c[4], z: c[5]};
    endtask

    // coordinates given as raw q8.8 integers, 256 = 1.0
    function automatic ray_t build_ray(shape_t shape, int sx, int sy, int sz,
                                       int dx, int dy, int dz);
        ray_t r;
        r.src   = '{x: coord_t'(sx), y: coord_t'(sy), z: coord_t'(sz)};
        r.dir   = '{x: coord_t'(dx), y: coord_t'(dy), z: coord_t'(dz)};
        r.shape = shape;
        return r;
    endfunction

    // |src + t*dir|^2 = 1 per shape, a2 = 2a, b, c2 = 2c at q16.16
    function automatic hit_t model_hit(ray_t r);
        longint             sx, sy, sz, dx, dy, dz;
        longint             a2, b, c2;
        logic signed [79:0] a2w, bw, c2w, disc;
        hit_t               h;
        sx = longint'(r.src.x);
        sy = longint'(r.src.y);
        sz = longint'(r.src.z);
        dx = longint'(r.dir.x);
        dy = longint'(r.dir.y);
        dz = longint'(r.dir.z);
        case (r.shape)
            shape_sphere: begin
                a2 = 2 * (dx * dx + dy * dy + dz * dz);
                b  = 2 * (dx * sx + dy * sy + dz * sz);
                c2 = 2 * (sx * sx + sy * sy + sz * sz) - 2 * q16_one;
            end
            shape_cylinder: begin       // z plays no part
                a2 = 2 * (dx * dx + dy * dy);
                b  = 2 * (dx * sx + dy * sy);
                c2 = 2 * (sx * sx + sy * sy) - 2 * q16_one;
            end
            shape_cone: begin           // x^2 + y^2 = z^2
                a2 = 2 * (dx * dx + dy * dy - dz * dz);
                b  = 2 * (dx * sx + dy * sy - dz * sz);
                c2 = 2 * (sx * sx + sy * sy - sz * sz);
            end
            default: begin              // off
                a2 = 2 * q16_one;
                b  = 0;
                c2 = 0;
            end
        endcase
        a2w  = a2;
        bw   = b;
        c2w  = c2;
        disc = bw * bw - a2w * c2w;     // b^2 - 4ac
        h.coeff.a2     = coeff_val_t'(a2);
        h.coeff.b      = coeff_val_t'(b);
        h.coeff.c2     = coeff_val_t'(c2);
        h.real_sol     = (disc >= 0);
        h.real_pos_sol = (a2 != 0) && h.real_sol
                         && ((a2 > 0 && c2 < 0) || (a2 < 0 && c2 > 0)
                             || (a2 > 0 && b < 0) || (a2 < 0 && b > 0));
        return h;
    endfunction

    // one falling edge: retire the hit seen at the last rising edge, then drive
    task automatic send_cycle(input logic valid, input ray_t r);
        @(negedge clk);
        if (hit_sampled && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            hits_checked++;
        end
        ray_valid = valid;
        ray       = r;
        if (valid) begin
            exp_q.push_back(model_hit(r));
            rays_sent++;
        end
        exp_avail = (exp_q.size() > 0);
        if (exp_avail) exp_head = exp_q[0];
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) send_cycle(1'b0, ray);
    endtask

    always @(posedge clk) begin
        hit_sampled <= hit_valid;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d hits still outstanding",
                     cycle_count, exp_q.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    a_reset_clears: assert property (@(posedge clk) !rst_n |=> !hit_valid)
        else report_other("hit_valid not cleared by reset");

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ray_valid |-> ##6 hit_valid)
        else report_other("hit_valid missing 6 cycles after ray_valid");

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> $past(ray_valid, 6))
        else report_other("hit_valid high without a ray 6 cycles earlier");

    a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> exp_avail)
        else report_other("hit_valid high with no ray outstanding");

    a_coeff_a2: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> hit.coeff.a2 == exp_head.coeff.a2)
        else report_value("hit.coeff.a2", exp_head.coeff.a2, $sampled(hit.coeff.a2));

    a_coeff_b: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> hit.coeff.b == exp_head.coeff.b)
        else report_value("hit.coeff.b", exp_head.coeff.b, $sampled(hit.coeff.b));

    a_coeff_c2: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> hit.coeff.c2 == exp_head.coeff.c2)
        else report_value("hit.coeff.c2", exp_head.coeff.c2, $sampled(hit.coeff.c2));

    a_real_sol: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> hit.real_sol == exp_head.real_sol)
        else report_value("hit.real_sol", exp_head.real_sol, $sampled(hit.real_sol));

    a_real_pos_sol: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> hit.real_pos_sol == exp_head.real_pos_sol)
        else report_value("hit.real_pos_sol", exp_head.real_pos_sol,
                          $sampled(hit.real_pos_sol));

    initial begin
        ray_t        r;
        logic [15:0] bits;
        ray_valid    = 1'b0;
        ray          = '0;
        exp_head     = '0;
        exp_avail    = 1'b0;
        lfsr         = 32'h14fa_ac8a;
        value_errors = 0;
        other_errors = 0;
        rays_sent    = 0;
        hits_checked = 0;
        wait (rst_n === 1'b1);
        idle_cycles(3);                 // hit_valid must stay low here

        // directed rays, back to back
        send_cycle(1'b1, build_ray(shape_off, 300, -700, 45, -20, 900, 13));
        send_cycle(1'b1, build_ray(shape_sphere, -512, 256, 0, 256, 0, 0));     // tangent
        send_cycle(1'b1, build_ray(shape_cylinder, 256, -768, 1280, 0, 256, 128)); // tangent
        send_cycle(1'b1, build_ray(shape_sphere, -768, 512, 0, 256, 0, 0));     // miss
        send_cycle(1'b1, build_ray(shape_sphere, 64, 0, 0, 0, 256, 0));         // inside
        send_cycle(1'b1, build_ray(shape_sphere, 0, 0, -768, 0, 0, 256));       // ahead
        send_cycle(1'b1, build_ray(shape_sphere, 0, 0, 768, 0, 0, 256));        // behind
        send_cycle(1'b1, build_ray(shape_cone, 0, 0, 512, 256, 0, 256));        // 2a = 0
        send_cycle(1'b1, build_ray(shape_cylinder, 128, 0, 1792, 256, 256, 768)); // inside
        send_cycle(1'b1, build_ray(shape_off, -1, 1, -1, 1, -1, 1));
        idle_cycles(8);

        // random rays with random single-cycle gaps
        for (int n = 0; n < random_rays; n++) begin
            random_ray(r);
            send_cycle(1'b1, r);
            take_bits(1, bits);
            if (bits[0]) send_cycle(1'b0, r);
        end

        while (exp_q.size() > 0) send_cycle(1'b0, ray);
        idle_cycles(4);                 // no stray hit_valid after the drain
        if (rays_sent != hits_checked) begin
            report_other("number of hits does not match number of rays");
        end

        $display("errors: %0d value, %0d other (%0d rays sent, %0d hits checked)",
                 value_errors, other_errors, rays_sent, hits_checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
common/quadric_pkg.sv
quadric/signed_dot3.sv
quadric/quadric_coeff.sv
logic/root_classify.sv
logic/ray_quadric_top.sv
dv/tb_clock.sv
dv/tb_ray_quadric.sv

//--- run.sh
#!/bin/sh
# build and run the ray quadric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ray_quadric -f sources.f -o sim_tb_ray_quadric

out=$(./obj_dir/sim_tb_ray_quadric)
echo "$out"

if echo "$out" | grep -q '\*\*\* PASSED \*\*\*'; then
    exit 0
fi
exit 1
